// File: Makefile
TOP := snake_game_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f common/snake_settings.svh $(shell grep -v '^+' tb.f)
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/snake_ctrl_pkg.sv
package snake_ctrl_pkg;

    // Game FSM states
    typedef enum logic [2:0] {
        RESTART,      // Load start values
        IDLE,         // Waiting for the first press
        WAIT,         // Game running, waiting for a tick
        MOVING,       // Head and body step
        MOVE_DONE,    // Crash and fruit checks on the new head
        EATEN,        // Grow, score, new fruit
        FRUIT_RETRY,  // Fruit placed again while it is blocked
        CRASHED       // Game over, press restarts
    } game_state_t;

endpackage

// File: common/snake_grid_pkg.sv
`include "snake_settings.svh"

package snake_grid_pkg;

    // One cell coordinate, 0..127 covers both axes
    typedef logic [6:0] coord_t;

    // Snake length, head included
    typedef logic [`LEN_BITS-1:0] len_t;

    // Score 0..99
    typedef logic [6:0] score_t;

    // Heading in clockwise order, so a turn is +1 or -1
    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_DOWN,
        HEAD_LEFT,
        HEAD_UP
    } heading_t;

endpackage

// File: common/snake_settings.svh
`ifndef SNAKE_SETTINGS_SVH
`define SNAKE_SETTINGS_SVH

// Play field size in cells
`define GRID_W 124
`define GRID_H 81

// Snake length counter, head included
`define LEN_BITS 6
`define LEN_MAX 63

// Start position, snake lies to the left of the head
`define START_HEAD_X 8
`define START_HEAD_Y 40
`define START_LEN 6

// First fruit sits right in front of the head
`define START_FRUIT_X 9
`define START_FRUIT_Y 40

// Seeds of the fruit position LFSRs, must be non zero
`define SEED_X 7'h1c
`define SEED_Y 7'h30

// Score wraps to 0 after this value
`define SCORE_WRAP 99

`endif

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock_25,
    output logic reset
);

    localparam real HALF_PERIOD = 2.0;  // 4 ns clock

    initial begin
        clock_25 = 1'b0;
        forever #(HALF_PERIOD) clock_25 = ~clock_25;
    end

    // Active low reset held over the first two rising edges
    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clock_25);
        #1 reset = 1'b1;  // Released at the drive point
    end

endmodule

// File: sim/snake_game_tb.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_game_tb
    import snake_grid_pkg::*;
();

    typedef enum {CMD_CHECK, CMD_PRESS_R, CMD_PRESS_L, CMD_PRESS_BOTH, CMD_TICK} cmd_t;

    // One stimulus line with the values expected after it
    typedef struct {
        cmd_t     cmd;
        int       count;      // Tick repeat
        coord_t   head_x;
        coord_t   head_y;
        heading_t heading;
        score_t   score;
        len_t     length;
        logic     start;
        logic     game_over;
    } step_t;

    localparam int TICK_GAP = 40;  // Idle cycles after each tick

    logic        clock_25;
    logic        reset;
    logic        game_tik;
    logic        right_press;
    logic        left_press;
    logic        start;
    logic        game_over;
    coord_t      head_x;
    coord_t      head_y;
    heading_t    heading;
    coord_t      fruit_x;
    coord_t      fruit_y;
    score_t      score;
    len_t        snake_length;
    step_t       steps[$];
    logic [31:0] lfsr = 32'h1321_710d;  // Gap generator state
    int          error_count = 0;
    int          tests_failed = 0;
    int          budget = 0;             // Watchdog limit in cycles
    score_t      prev_score = '0;

    clock_gen clock_gen_inst (.clock_25(clock_25), .reset(reset));

    snake_game snake_game_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .game_tik     (game_tik),
        .right_press  (right_press),
        .left_press   (left_press),
        .start        (start),
        .game_over    (game_over),
        .head_x       (head_x),
        .head_y       (head_y),
        .heading      (heading),
        .fruit_x      (fruit_x),
        .fruit_y      (fruit_y),
        .score        (score),
        .snake_length (snake_length)
    );

    // Galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 32'h8020_0003;
        end
        return value >> 1;
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);  // One step per bit
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // Ends 1 ns after a rising edge, where inputs change
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clock_25);
            #1;
        end
    endtask

    task automatic push_buttons(input logic right, input logic left);
        right_press = right;
        left_press  = left;
        wait_cycles(3);
        right_press = 1'b0;
        left_press  = 1'b0;
        wait_cycles(10);  // Synchroniser and FSM settle
    endtask

    task automatic send_tick();
        game_tik = 1'b1;
        wait_cycles(1);
        game_tik = 1'b0;
        wait_cycles(TICK_GAP);
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            error_count++;
        end
    endtask

    task automatic check_heading(input heading_t got, input heading_t want);
        if (got !== want) begin
            $display("FAILED heading: got 0x%h, expected 0x%h", got, want);
            error_count++;
        end
    endtask

    task automatic check_score(input score_t got, input score_t want);
        if (got !== want) begin
            $display("FAILED score: got 0x%h, expected 0x%h", got, want);
            error_count++;
        end
    endtask

    task automatic check_len(input len_t got, input len_t want);
        if (got !== want) begin
            $display("FAILED snake_length: got 0x%h, expected 0x%h", got, want);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            error_count++;
        end
    endtask

    // New fruit must be inside the border and off the head
    task automatic check_fruit_placed();
        if (fruit_x < 7'd1 || fruit_x > coord_t'(`GRID_W - 2) ||
            fruit_y < 7'd1 || fruit_y > coord_t'(`GRID_H - 2)) begin
            $display("Fruit at (%0d,%0d) lies outside the playing area", fruit_x, fruit_y);
            error_count++;
        end
        if (fruit_x == head_x && fruit_y == head_y) begin
            $display("Fruit at (%0d,%0d) was placed on the head", fruit_x, fruit_y);
            error_count++;
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    fields;
        int    line_no;
        int    total;
        int    v [7];
        logic  known;
        string line;
        string word;
        step_t s;
        total = 0;
        line_no = 0;
        fd = $fopen("sim/snake_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/snake_stimulus.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
                fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d", word, s.count,
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                known = 1'b1;
                case (word)
                    "CHECK":      s.cmd = CMD_CHECK;
                    "PRESS_R":    s.cmd = CMD_PRESS_R;
                    "PRESS_L":    s.cmd = CMD_PRESS_L;
                    "PRESS_BOTH": s.cmd = CMD_PRESS_BOTH;
                    "TICK":       s.cmd = CMD_TICK;
                    default:      known = 1'b0;
                endcase
                if (fields != 9 || !known) begin
                    $display("Stimulus line %0d cannot be read", line_no);
                    error_count++;
                end else begin
                    s.head_x    = coord_t'(v[0]);
                    s.head_y    = coord_t'(v[1]);
                    s.heading   = heading_t'(v[2][1:0]);
                    s.score     = score_t'(v[3]);
                    s.length    = len_t'(v[4]);
                    s.start     = v[5][0];
                    s.game_over = v[6][0];
                    steps.push_back(s);
                    // Gap of up to 7 plus the command itself
                    total += 8 + ((s.cmd == CMD_TICK) ? s.count * (TICK_GAP + 1) : 13);
                end
            end
            $fclose(fd);
        end
        budget = total + 100;  // Reset and margin
    endtask

    task automatic run_step(input int idx);
        step_t s;
        int    gap;
        int    errors_before;
        s = steps[idx];
        errors_before = error_count;
        draw_bits(3, gap);
        wait_cycles(gap);
        case (s.cmd)
            CMD_PRESS_R:    push_buttons(1'b1, 1'b0);
            CMD_PRESS_L:    push_buttons(1'b0, 1'b1);
            CMD_PRESS_BOTH: push_buttons(1'b1, 1'b1);
            CMD_TICK:       repeat (s.count) send_tick();
            default:        ;
        endcase
        check_coord("head_x", head_x, s.head_x);
        check_coord("head_y", head_y, s.head_y);
        check_heading(heading, s.heading);
        check_score(score, s.score);
        check_len(snake_length, s.length);
        check_flag("start", start, s.start);
        check_flag("game_over", game_over, s.game_over);
        if (!s.start && !s.game_over) begin
            // Idle, fruit back on its start cell
            check_coord("fruit_x", fruit_x, coord_t'(`START_FRUIT_X));
            check_coord("fruit_y", fruit_y, coord_t'(`START_FRUIT_Y));
        end else if (s.score != prev_score) begin
            check_fruit_placed();  // A fruit was eaten
        end
        prev_score = s.score;
        if (error_count == errors_before) begin
            $display("Test %0d %s x%0d ok", idx + 1, s.cmd.name(), s.count);
        end else begin
            $display("Test %0d %s x%0d failed", idx + 1, s.cmd.name(), s.count);
            tests_failed++;
        end
    endtask

    initial begin
        game_tik    = 1'b0;
        right_press = 1'b0;
        left_press  = 1'b0;
        load_stimulus();
        if (steps.size() == 0) begin
            $display("No stimulus steps were loaded");
            error_count++;
        end
        wait (reset === 1'b1);
        wait_cycles(2);  // RESTART, then IDLE
        foreach (steps[i]) begin
            run_step(i);
        end
        $display("Tests run %0d, failed %0d, errors %0d", steps.size(), tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clock_25);
        $display("Watchdog expired after %0d cycles, the run did not complete", budget);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sim/snake_stimulus.txt
# command count head_x head_y heading score length start game_over, all decimal
# heading 0 right 1 down 2 left 3 up; count is the tick repeat, 1 for other commands
CHECK      1   8 40 0 0 6 0 0
PRESS_R    1   8 40 0 0 6 1 0
TICK       1   9 40 0 1 7 1 0
PRESS_R    1   9 40 0 1 7 1 0
TICK       1   9 41 1 1 7 1 0
PRESS_L    1   9 41 1 1 7 1 0
TICK       1  10 41 0 1 7 1 0
PRESS_BOTH 1  10 41 0 1 7 1 0
TICK       1  11 41 0 1 7 1 0
PRESS_L    1  11 41 0 1 7 1 0
TICK       1  11 40 3 1 7 1 0
TICK      39  11  1 3 1 7 1 0
TICK       1  11  0 3 1 7 0 1
TICK       3  11  0 3 1 7 0 1
PRESS_R    1   8 40 0 0 6 0 0
PRESS_L    1   8 40 0 0 6 1 0
TICK       1   9 40 0 1 7 1 0
PRESS_R    1   9 40 0 1 7 1 0
TICK       2   9 42 1 1 7 1 0

// File: snake/fruit_ctrl.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module fruit_ctrl
    import snake_grid_pkg::*;
(
    input  logic   clock_25,
    input  logic   reset,
    input  logic   restart,
    input  logic   grow_en,    // Fruit eaten, place a new one
    input  logic   retry_en,   // Placement check running
    input  coord_t head_x,
    input  coord_t head_y,
    input  logic   query_hit,  // Fruit cell is on the snake
    output coord_t fruit_x,
    output coord_t fruit_y,
    output score_t score,
    output logic   eaten,
    output logic   blocked
);

    coord_t lfsr_x;
    coord_t lfsr_y;
    logic   border_fruit;

    // Galois step, x^7 + x^6 + 1
    function automatic coord_t lfsr_step(input coord_t value);
        coord_t fb;
        fb = {7{value[6]}} & 7'h41;
        return {value[5:0], 1'b0} ^ fb;
    endfunction

    // Free running, the game timing picks the sample
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr_x <= `SEED_X;
            lfsr_y <= `SEED_Y;
        end else begin
            lfsr_x <= lfsr_step(lfsr_x);
            lfsr_y <= lfsr_step(lfsr_y);
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit_x <= coord_t'(`START_FRUIT_X);
            fruit_y <= coord_t'(`START_FRUIT_Y);
            score   <= '0;
        end else if (restart) begin
            fruit_x <= coord_t'(`START_FRUIT_X);
            fruit_y <= coord_t'(`START_FRUIT_Y);
            score   <= '0;
        end else if (grow_en) begin
            fruit_x <= lfsr_x;
            fruit_y <= lfsr_y;
            if (score == score_t'(`SCORE_WRAP)) begin
                score <= '0;
            end else begin
                score <= score + 7'd1;
            end
        end else if (retry_en && blocked) begin
            fruit_x <= lfsr_x;  // Fresh sample until it lands free
            fruit_y <= lfsr_y;
        end
    end

    assign eaten = (fruit_x == head_x) && (fruit_y == head_y);

    // Border cells and everything outside the grid
    assign border_fruit = (fruit_x == 7'd0) || (fruit_y == 7'd0) ||
                          (fruit_x >= coord_t'(`GRID_W - 1)) ||
                          (fruit_y >= coord_t'(`GRID_H - 1));

    assign blocked = query_hit | border_fruit;

endmodule

// File: snake/snake_body.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_body
    import snake_grid_pkg::*;
(
    input  logic     clock_25,
    input  logic     reset,
    input  logic     restart,
    input  logic     move_en,
    input  logic     grow_en,
    input  logic     turn_cw,
    input  logic     turn_ccw,
    input  coord_t   query_x,       // Cell asked about by fruit_ctrl
    input  coord_t   query_y,
    output coord_t   head_x,
    output coord_t   head_y,
    output heading_t heading,
    output len_t     snake_length,
    output logic     crash,
    output logic     query_hit      // Query cell is on the snake
);

    localparam int SEGS = `LEN_MAX - 1;  // Body segments behind the head

    coord_t   body_x [SEGS];
    coord_t   body_y [SEGS];
    heading_t heading_next;
    len_t     active_segs;  // Segments in use
    logic     border_hit;
    logic     body_hit;
    logic     query_body;

    assign active_segs = snake_length - 1'b1;

    // Rotate by the pending turn
    always_comb begin
        heading_next = heading;
        if (turn_cw) begin
            heading_next = heading_t'(heading + 2'd1);
        end else if (turn_ccw) begin
            heading_next = heading_t'(heading - 2'd1);
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head_x       <= coord_t'(`START_HEAD_X);
            head_y       <= coord_t'(`START_HEAD_Y);
            heading      <= HEAD_RIGHT;
            snake_length <= len_t'(`START_LEN);
        end else if (restart) begin
            head_x       <= coord_t'(`START_HEAD_X);
            head_y       <= coord_t'(`START_HEAD_Y);
            heading      <= HEAD_RIGHT;
            snake_length <= len_t'(`START_LEN);
        end else if (move_en) begin
            heading <= heading_next;
            // One cell along the new heading
            case (heading_next)
                HEAD_RIGHT: head_x <= head_x + 7'd1;
                HEAD_DOWN:  head_y <= head_y + 7'd1;
                HEAD_LEFT:  head_x <= head_x - 7'd1;
                HEAD_UP:    head_y <= head_y - 7'd1;
                default:    head_x <= head_x;
            endcase
        end else if (grow_en && snake_length < len_t'(`LEN_MAX)) begin
            snake_length <= snake_length + 1'b1;  // Saturates at the maximum
        end
    end

    // Body shift register, old head enters at segment 0
    always_ff @(posedge clock_25) begin
        if (restart) begin
            for (int i = 0; i < SEGS; i++) begin
                if (i < `START_LEN - 1) begin
                    body_x[i] <= coord_t'(`START_HEAD_X - i - 1);  // Laid out leftwards
                    body_y[i] <= coord_t'(`START_HEAD_Y);
                end else begin
                    body_x[i] <= 7'h7f;  // Off grid, never matches
                    body_y[i] <= 7'h7f;
                end
            end
        end else if (move_en) begin
            body_x[0] <= head_x;
            body_y[0] <= head_y;
            for (int i = 1; i < SEGS; i++) begin
                if (i < int'(active_segs)) begin
                    body_x[i] <= body_x[i-1];
                    body_y[i] <= body_y[i-1];
                end
            end
        end
    end

    // Head or query against every active segment
    always_comb begin
        body_hit   = 1'b0;
        query_body = 1'b0;
        for (int i = 0; i < SEGS; i++) begin
            if (i < int'(active_segs)) begin
                if (body_x[i] == head_x && body_y[i] == head_y) body_hit = 1'b1;
                if (body_x[i] == query_x && body_y[i] == query_y) query_body = 1'b1;
            end
        end
    end

    assign border_hit = (head_x == 7'd0) || (head_y == 7'd0) ||
                        (head_x == coord_t'(`GRID_W - 1)) ||
                        (head_y == coord_t'(`GRID_H - 1));

    assign crash     = border_hit | body_hit;
    assign query_hit = query_body | (query_x == head_x && query_y == head_y);

    // Growth never goes past the limits
    a_len_range: assert property (@(posedge clock_25) disable iff (!reset)
        snake_length >= len_t'(`START_LEN) && snake_length <= len_t'(`LEN_MAX));

endmodule

// File: snake/snake_fsm.sv
`timescale 1ns/1ps

module snake_fsm
    import snake_ctrl_pkg::*;
(
    input  logic clock_25,
    input  logic reset,
    input  logic press,       // Button edge from turn_input
    input  logic game_tik,    // Move rate
    input  logic crash,       // Head on border or body
    input  logic eaten,       // Head on fruit
    input  logic blocked,     // Fruit on snake or border
    output logic move_en,
    output logic grow_en,
    output logic retry_en,
    output logic restart,
    output logic start,
    output logic game_over
);

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state <= RESTART;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;  // Hold by default
        case (state)
            RESTART: state_next = IDLE;
            IDLE: begin
                if (press) state_next = WAIT;  // First press starts the game
            end
            WAIT: begin
                if (game_tik) state_next = MOVING;  // Ticks elsewhere are ignored
            end
            MOVING: state_next = MOVE_DONE;
            MOVE_DONE: begin
                // Crash wins over a fruit on the same cell
                if (crash) begin
                    state_next = CRASHED;
                end else if (eaten) begin
                    state_next = EATEN;
                end else begin
                    state_next = WAIT;
                end
            end
            EATEN: state_next = FRUIT_RETRY;
            FRUIT_RETRY: begin
                if (!blocked) state_next = WAIT;  // Fruit landed on a free cell
            end
            CRASHED: begin
                if (press) state_next = RESTART;
            end
            default: state_next = RESTART;
        endcase
    end

    // Moore outputs
    assign move_en   = (state == MOVING);
    assign grow_en   = (state == EATEN);
    assign retry_en  = (state == FRUIT_RETRY);
    assign restart   = (state == RESTART);
    assign game_over = (state == CRASHED);

    always_comb begin
        case (state)
            WAIT, MOVING, MOVE_DONE, EATEN, FRUIT_RETRY: start = 1'b1;
            default: start = 1'b0;
        endcase
    end

    // Running and game over exclude each other
    a_start_over: assert property (@(posedge clock_25) disable iff (!reset)
        !(start && game_over));

    // One step per tick
    a_move_pulse: assert property (@(posedge clock_25) disable iff (!reset)
        move_en |=> !move_en);

endmodule

// File: src/snake_game.sv
`timescale 1ns/1ps

module snake_game
    import snake_grid_pkg::*;
(
    input  logic     clock_25,
    input  logic     reset,
    input  logic     game_tik,
    input  logic     right_press,
    input  logic     left_press,
    output logic     start,
    output logic     game_over,
    output coord_t   head_x,
    output coord_t   head_y,
    output heading_t heading,
    output coord_t   fruit_x,
    output coord_t   fruit_y,
    output score_t   score,
    output len_t     snake_length
);

    logic press;
    logic turn_cw;
    logic turn_ccw;
    logic move_en;
    logic grow_en;
    logic retry_en;
    logic restart;
    logic crash;
    logic eaten;
    logic blocked;
    logic query_hit;

    turn_input turn_input_inst (
        .clock_25    (clock_25),
        .reset       (reset),
        .right_press (right_press),
        .left_press  (left_press),
        .active      (start),     // Turns only while running
        .move_en     (move_en),
        .restart     (restart),
        .press       (press),
        .turn_cw     (turn_cw),
        .turn_ccw    (turn_ccw)
    );

    snake_fsm snake_fsm_inst (
        .clock_25  (clock_25),
        .reset     (reset),
        .press     (press),
        .game_tik  (game_tik),
        .crash     (crash),
        .eaten     (eaten),
        .blocked   (blocked),
        .move_en   (move_en),
        .grow_en   (grow_en),
        .retry_en  (retry_en),
        .restart   (restart),
        .start     (start),
        .game_over (game_over)
    );

    snake_body snake_body_inst (
        .clock_25     (clock_25),
        .reset        (reset),
        .restart      (restart),
        .move_en      (move_en),
        .grow_en      (grow_en),
        .turn_cw      (turn_cw),
        .turn_ccw     (turn_ccw),
        .query_x      (fruit_x),   // Occupancy check on the fruit cell
        .query_y      (fruit_y),
        .head_x       (head_x),
        .head_y       (head_y),
        .heading      (heading),
        .snake_length (snake_length),
        .crash        (crash),
        .query_hit    (query_hit)
    );

    fruit_ctrl fruit_ctrl_inst (
        .clock_25  (clock_25),
        .reset     (reset),
        .restart   (restart),
        .grow_en   (grow_en),
        .retry_en  (retry_en),
        .head_x    (head_x),
        .head_y    (head_y),
        .query_hit (query_hit),
        .fruit_x   (fruit_x),
        .fruit_y   (fruit_y),
        .score     (score),
        .eaten     (eaten),
        .blocked   (blocked)
    );

endmodule

// File: src/turn_input.sv
`timescale 1ns/1ps

module turn_input (
    input  logic clock_25,
    input  logic reset,
    input  logic right_press,
    input  logic left_press,
    input  logic active,       // Game running
    input  logic move_en,      // Pending turn is used up
    input  logic restart,
    output logic press,        // Any new button edge
    output logic turn_cw,
    output logic turn_ccw
);

    logic [1:0] right_sync;    // Two stage synchroniser
    logic [1:0] left_sync;
    logic       right_last;    // Previous synchronised level
    logic       left_last;
    logic       right_rise;    // Registered edge pulses
    logic       left_rise;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_sync <= 2'b00;
            left_sync  <= 2'b00;
            right_last <= 1'b0;
            left_last  <= 1'b0;
            right_rise <= 1'b0;
            left_rise  <= 1'b0;
        end else begin
            right_sync <= {right_sync[0], right_press};
            left_sync  <= {left_sync[0], left_press};
            right_last <= right_sync[1];
            left_last  <= left_sync[1];
            right_rise <= right_sync[1] & ~right_last;  // Rising edge only
            left_rise  <= left_sync[1] & ~left_last;
        end
    end

    assign press = right_rise | left_rise;  // Starts and restarts the game

    // Pending turn, held until the next move
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (restart) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (active && press) begin
            turn_cw  <= right_rise & ~left_rise;  // Both buttons cancel
            turn_ccw <= left_rise & ~right_rise;
        end else if (move_en) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end
    end

    // Only one turn direction can be pending
    a_one_turn: assert property (@(posedge clock_25) disable iff (!reset)
        !(turn_cw && turn_ccw));

endmodule

// File: tb.f
+incdir+common
common/snake_ctrl_pkg.sv
common/snake_grid_pkg.sv
src/turn_input.sv
snake/snake_fsm.sv
snake/snake_body.sv
snake/fruit_ctrl.sv
src/snake_game.sv
sim/clock_gen.sv
sim/snake_game_tb.sv
